/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert
TOP = layerTb
FILELIST = verilog.f
BUILD_DIR = obj_dir

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) verilog/layer_cfg.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run fails unless the pass message shows up in the output.
run: $(SIM_BIN)
	out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf $(BUILD_DIR)

/* sim/layerTb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "layer_cfg.svh"

module layerTb
	import layerPkg::*;
();

	localparam int NI = `NUM_INPUTS;
	localparam int NN = `NUM_NEURONS;
	// every random run counts as a test of its own.
	localparam int NUM_TESTS = 25;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 2000;
	localparam int USED_WORDS = 48;

	logic clk = 1'b0;
	logic reset;
	axiReq_t axi;
	axiRsp_t axiOut;
	int errorCount = 0;

	int actData [NI];
	int wgtData [NN][NI];
	int biasData [NN];
	logic [31:0] memImage [USED_WORDS];

	string nameQ [$];
	logic [31:0] expQ [$];
	logic [31:0] actQ [$];
	string cmpName;
	logic [31:0] cmpExp;
	logic [31:0] cmpAct;

	layerTop layerTop_i (
		.clk(clk),
		.reset(reset),
		.axi(axi),
		.axiOut(axiOut)
	);

	always #20 clk = ~clk;

	// expected output of neuron j, a ReLU on a sum with 13 fraction bits.
	function automatic logic [31:0] neuronRef(input int j);
		logic [31:0] sum;
		sum = biasData[j];
		for (int i = 0; i < NI; i++)
			sum = sum + 32'(actData[i] * wgtData[j][i]);
		if (sum[31])
			return 32'd0;
		return {16'd0, sum[28:13]};
	endfunction

	function automatic logic [11:0] windowAddr(input int word);
		return 12'(`MEM_WINDOW + 4 * word);
	endfunction

	// ****************************************
	// AXI4-Lite host tasks
	// ****************************************

	// both tasks start and end 2 ns after a rising edge.
	task automatic axiWrite(input logic [11:0] addr, input logic [31:0] data);
		axi.awvalid = 1'b1;
		axi.awaddr = addr;
		axi.wvalid = 1'b1;
		axi.wdata = data;
		axi.wstrb = 4'hf;
		axi.bready = 1'b1;
		@(negedge clk);
		while (!(axiOut.awready && axiOut.wready))
			@(negedge clk);
		@(posedge clk);
		#2;
		axi.awvalid = 1'b0;
		axi.wvalid = 1'b0;
		@(negedge clk);
		while (!axiOut.bvalid)
			@(negedge clk);
		expectValue($sformatf("write response %h", addr), 32'd0, 32'(axiOut.bresp));
		@(posedge clk);
		#2;
		axi.bready = 1'b0;
	endtask

	task automatic axiRead(input logic [11:0] addr, output logic [31:0] data);
		axi.arvalid = 1'b1;
		axi.araddr = addr;
		axi.rready = 1'b1;
		@(negedge clk);
		while (!axiOut.arready)
			@(negedge clk);
		@(posedge clk);
		#2;
		axi.arvalid = 1'b0;
		@(negedge clk);
		while (!axiOut.rvalid)
			@(negedge clk);
		data = axiOut.rdata;
		expectValue($sformatf("read response %h", addr), 32'd0, 32'(axiOut.rresp));
		@(posedge clk);
		#2;
		axi.rready = 1'b0;
	endtask

	task automatic expectValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		nameQ.push_back(name);
		expQ.push_back(expected);
		actQ.push_back(actual);
	endtask

	task automatic readExpect(input string name, input logic [11:0] addr,
		input logic [31:0] expected);
		logic [31:0] value;
		axiRead(addr, value);
		expectValue(name, expected, value);
	endtask

	// ****************************************
	// layer tasks
	// ****************************************

	task automatic loadLayer();
		int base;
		for (int i = 0; i < NI; i++)
			axiWrite(windowAddr(`ACT_BASE + i), actData[i]);
		for (int j = 0; j < NN; j++)
		begin
			base = `NEURON_BASE + j * `NEURON_STRIDE;
			for (int i = 0; i < NI; i++)
				axiWrite(windowAddr(base + i), wgtData[j][i]);
			axiWrite(windowAddr(base + NI), biasData[j]);
		end
	endtask

	task automatic waitDone();
		logic [31:0] status;
		status = '0;
		while (!status[1])
			axiRead(12'(`REG_STATUS), status);
	endtask

	task automatic compareResults(input string name);
		logic [31:0] value;
		for (int j = 0; j < NN; j++)
		begin
			axiRead(12'(`REG_RESULT_BASE + 4 * j), value);
			expectValue($sformatf("%s neuron %0d", name, j), neuronRef(j), value);
		end
	endtask

	task automatic runLayer(input string name);
		loadLayer();
		axiWrite(12'(`REG_CTRL), 32'd1);
		waitDone();
		compareResults(name);
	endtask

	// operands in the signed 16-bit range.
	task automatic randomData();
		for (int i = 0; i < NI; i++)
			actData[i] = int'($urandom_range(65535)) - 32768;
		for (int j = 0; j < NN; j++)
		begin
			for (int i = 0; i < NI; i++)
				wgtData[j][i] = int'($urandom_range(65535)) - 32768;
			biasData[j] = int'($urandom_range(65535)) - 32768;
		end
	endtask

	always @(posedge clk)
	begin
		while (expQ.size() > 0)
		begin
			cmpName = nameQ.pop_front();
			cmpExp = expQ.pop_front();
			cmpAct = actQ.pop_front();
			assert (cmpAct == cmpExp)
			else
			begin
				$display("MISMATCH %s expected %h actual %h", cmpName, cmpExp, cmpAct);
				errorCount++;
			end
		end
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout: the layer tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("errors: %0d", errorCount + 1);
		$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		int refWeights [NI];
		void'($urandom(32'he772));
		refWeights = '{-1938, 878, 9, 1503, -744, 2210, -391, 65, -1287, 1750,
			431, -2566, 307, -918, 1144};
		reset = 1'b1;
		axi = '0;
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;
		@(posedge clk);
		#2;

		// after reset every register reads zero.
		readExpect("reset status", 12'(`REG_STATUS), 32'd0);
		for (int j = 0; j < NN; j++)
			readExpect($sformatf("reset result %0d", j), 12'(`REG_RESULT_BASE + 4 * j), 32'd0);

		for (int w = 0; w < USED_WORDS; w++)
		begin
			memImage[w] = $urandom();
			axiWrite(windowAddr(w), memImage[w]);
		end
		for (int w = 0; w < USED_WORDS; w++)
			readExpect($sformatf("memory word %0d", w), windowAddr(w), memImage[w]);
		axiWrite(12'h100, 32'hdeadbeef);
		readExpect("unmapped 0x100", 12'h100, 32'd0);
		readExpect("unmapped 0x008", 12'h008, 32'd0);
		readExpect("unmapped 0x3fc", 12'h3fc, 32'd0);
		readExpect("unmapped 0x500", 12'h500, 32'd0);
		readExpect("unmapped 0xffc", 12'hffc, 32'd0);

		// neuron 1 mirrors neuron 0 with every sign flipped.
		for (int i = 0; i < NI; i++)
		begin
			actData[i] = 8192 + 512 * i;
			wgtData[0][i] = refWeights[i];
			wgtData[1][i] = -refWeights[i];
		end
		biasData[0] = -52;
		biasData[1] = 52;
		runLayer("fixed run");

		for (int i = 0; i < NI; i++)
		begin
			actData[i] = 1000 + 37 * i;
			wgtData[0][i] = -4096;
			wgtData[1][i] = 0;
		end
		wgtData[1][3] = 7;
		biasData[0] = -1;
		biasData[1] = int'(32'h3abcd5a7);
		runLayer("negative sum");
		readExpect("negative sum clamp", 12'(`REG_RESULT_BASE), 32'd0);

		for (int r = 0; r < 20; r++)
		begin
			randomData();
			runLayer($sformatf("random run %0d", r));
		end

		// the second start lands while the engines are busy.
		randomData();
		loadLayer();
		axiWrite(12'(`REG_CTRL), 32'd1);
		axiWrite(12'(`REG_CTRL), 32'd1);
		readExpect("start while busy status", 12'(`REG_STATUS), 32'd1);
		waitDone();
		readExpect("start while busy done", 12'(`REG_STATUS), 32'd2);
		compareResults("start while busy");

		while (expQ.size() != 0)
			@(negedge clk);
		$display("errors: %0d", errorCount);
		if (errorCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verilog
verilog/layerPkg.sv
verilog/axiLiteRegs.sv
verilog/memArbiter.sv
verilog/layerMemory.sv
verilog/neuronEngine.sv
verilog/layerTop.sv
sim/layerTb.sv

/* verilog/axiLiteRegs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "layer_cfg.svh"

module axiLiteRegs
	import layerPkg::*;
(
	input wire clk,
	input wire reset,
	input wire axiReq_t axi,
	output axiRsp_t axiOut,
	output memReq_t memReq,
	input wire memRsp_t memRsp,
	output logic start,
	input wire [`NUM_NEURONS-1:0] engineDone,
	input wire [`NUM_NEURONS-1:0][31:0] engineResult
);

	localparam int AXW = `AXI_ADDR_W;
	localparam int AW = `MEM_ADDR_W;

	typedef enum logic [2:0] {idle, wrMem, wrResp, rdMem, rdWait, rdResp} state_t;

	state_t state;
	logic busy;
	logic done;
	logic [`NUM_NEURONS-1:0] doneSeen;
	logic [`NUM_NEURONS-1:0] doneAll;
	logic [`NUM_NEURONS-1:0][31:0] results;
	logic [31:0] rdData;
	logic [AW-1:0] memAddr;
	logic [31:0] memWdata;
	logic wrAccept;
	logic rdAccept;
	logic [AXW-1:0] wrWord;
	logic [AXW-1:0] rdWord;
	logic [AXW-1:0] wrOffset;
	logic [AXW-1:0] rdOffset;
	logic wrInWindow;
	logic rdInWindow;
	logic [31:0] regRead;

	// one transaction at a time, and a write wins over a read in the same cycle.
	assign wrAccept = (state == idle) && axi.awvalid && axi.wvalid;
	assign rdAccept = (state == idle) && axi.arvalid && !(axi.awvalid && axi.wvalid);

	assign wrWord = {axi.awaddr[AXW-1:2], 2'b00};
	assign rdWord = {axi.araddr[AXW-1:2], 2'b00};
	assign wrOffset = axi.awaddr - AXW'(`MEM_WINDOW);
	assign rdOffset = axi.araddr - AXW'(`MEM_WINDOW);
	assign wrInWindow = (axi.awaddr >= AXW'(`MEM_WINDOW)) && (wrOffset < AXW'(4 * `MEM_DEPTH));
	assign rdInWindow = (axi.araddr >= AXW'(`MEM_WINDOW)) && (rdOffset < AXW'(4 * `MEM_DEPTH));

	// the control register is write only and reads back as zero.
	always_comb
	begin
		regRead = '0;
		if (rdWord == AXW'(`REG_STATUS))
			regRead = {30'b0, done, busy};
		for (int k = 0; k < `NUM_NEURONS; k++)
		begin
			if (rdWord == AXW'(`REG_RESULT_BASE + 4 * k))
				regRead = results[k];
		end
	end

	// ****************************************
	// transaction FSM
	// ****************************************

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			start <= 1'b0;
		end
		else
		begin
			start <= 1'b0;
			case (state)
				idle:
				begin
					if (wrAccept)
					begin
						// the memory has no byte enables, so only full words reach it.
						if (wrInWindow && (&axi.wstrb))
							state <= wrMem;
						else
							state <= wrResp;
						if (wrWord == AXW'(`REG_CTRL) && axi.wstrb[0] && axi.wdata[0]
							&& !busy)
							start <= 1'b1;
					end
					else if (rdAccept)
					begin
						state <= rdInWindow ? rdMem : rdResp;
					end
				end
				wrMem:
				begin
					if (memRsp.gnt)
						state <= wrResp;
				end
				wrResp:
				begin
					if (axi.bready)
						state <= idle;
				end
				rdMem:
				begin
					if (memRsp.gnt)
						state <= rdWait;
				end
				rdWait:
				begin
					if (memRsp.rdValid)
						state <= rdResp;
				end
				rdResp:
				begin
					if (axi.rready)
						state <= idle;
				end
				default:
				begin
					state <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (wrAccept)
		begin
			memAddr <= wrOffset[AW+1:2];
			memWdata <= axi.wdata;
		end
		else if (rdAccept)
		begin
			memAddr <= rdOffset[AW+1:2];
			rdData <= regRead;
		end
		if (state == rdWait && memRsp.rdValid)
			rdData <= memRsp.rdata;
	end

	// ****************************************
	// layer status and results
	// ****************************************

	assign doneAll = doneSeen | engineDone;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			doneSeen <= '0;
			results <= '0;
		end
		else
		begin
			for (int k = 0; k < `NUM_NEURONS; k++)
			begin
				if (engineDone[k])
					results[k] <= engineResult[k];
			end
			if (start)
			begin
				busy <= 1'b1;
				done <= 1'b0;
				doneSeen <= '0;
			end
			else if (busy)
			begin
				if (&doneAll)
				begin
					busy <= 1'b0;
					done <= 1'b1;
					doneSeen <= '0;
				end
				else
				begin
					doneSeen <= doneAll;
				end
			end
		end
	end

	always_comb
	begin
		axiOut.awready = wrAccept;
		axiOut.wready = wrAccept;
		axiOut.bvalid = (state == wrResp);
		axiOut.bresp = 2'b00;
		axiOut.arready = rdAccept;
		axiOut.rvalid = (state == rdResp);
		axiOut.rdata = rdData;
		axiOut.rresp = 2'b00;
		memReq.req = (state == wrMem) || (state == rdMem);
		memReq.write = (state == wrMem);
		memReq.addr = memAddr;
		memReq.wdata = memWdata;
	end

endmodule

`default_nettype wire

/* verilog/layerMemory.sv */
`timescale 1ns/1ns
`default_nettype none

`include "layer_cfg.svh"

module layerMemory
	import layerPkg::*;
(
	input wire clk,
	input wire memReq_t memReq,
	output logic [31:0] rdata
);

	logic [31:0] mem [`MEM_DEPTH];

	// rdata only changes on a read, one cycle after the request.
	always_ff @(posedge clk)
	begin
		if (memReq.req)
		begin
			if (memReq.write)
				mem[memReq.addr] <= memReq.wdata;
			else
				rdata <= mem[memReq.addr];
		end
	end

endmodule

`default_nettype wire

/* verilog/layerPkg.sv */
`default_nettype none

`include "layer_cfg.svh"

package layerPkg;

	// ****************************************
	// layer memory port
	// ****************************************

	typedef struct packed {
		logic req;
		logic write;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [31:0] wdata;
	} memReq_t;

	typedef struct packed {
		logic gnt;
		logic rdValid;
		logic [31:0] rdata;
	} memRsp_t;

	// ****************************************
	// AXI4-Lite channels
	// ****************************************

	typedef struct packed {
		logic awvalid;
		logic [`AXI_ADDR_W-1:0] awaddr;
		logic wvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic bready;
		logic arvalid;
		logic [`AXI_ADDR_W-1:0] araddr;
		logic rready;
	} axiReq_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [31:0] rdata;
		logic [1:0] rresp;
	} axiRsp_t;

endpackage

`default_nettype wire

/* verilog/layerTop.sv */
`timescale 1ns/1ns
`default_nettype none

`include "layer_cfg.svh"

module layerTop
	import layerPkg::*;
(
	input wire clk,
	input wire reset,
	input wire axiReq_t axi,
	output axiRsp_t axiOut
);

	localparam int NUM_PORTS = `NUM_NEURONS + 1;
	localparam int AW = `MEM_ADDR_W;

	// port 0 is the register block, the engines follow it.
	memReq_t portReq [NUM_PORTS];
	memRsp_t portRsp [NUM_PORTS];
	memReq_t memReq;
	logic [31:0] memRdata;
	logic start;
	logic [`NUM_NEURONS-1:0] engineDone;
	logic [`NUM_NEURONS-1:0][31:0] engineResult;

	axiLiteRegs regs_i (
		.clk(clk),
		.reset(reset),
		.axi(axi),
		.axiOut(axiOut),
		.memReq(portReq[0]),
		.memRsp(portRsp[0]),
		.start(start),
		.engineDone(engineDone),
		.engineResult(engineResult)
	);

	for (genvar j = 0; j < `NUM_NEURONS; j++)
	begin : engine
		neuronEngine engine_i (
			.clk(clk),
			.reset(reset),
			.start(start),
			.neuronBase(AW'(`NEURON_BASE + j * `NEURON_STRIDE)),
			.memReq(portReq[j + 1]),
			.memRsp(portRsp[j + 1]),
			.done(engineDone[j]),
			.result(engineResult[j])
		);
	end

	memArbiter #(
		.NUM_PORTS(NUM_PORTS)
	) arbiter_i (
		.clk(clk),
		.reset(reset),
		.portReq(portReq),
		.portRsp(portRsp),
		.memReq(memReq),
		.memRdata(memRdata)
	);

	layerMemory memory_i (
		.clk(clk),
		.memReq(memReq),
		.rdata(memRdata)
	);

endmodule

`default_nettype wire

/* verilog/layer_cfg.svh */
`ifndef LAYER_CFG_SVH
`define LAYER_CFG_SVH

// layer geometry.
`define NUM_NEURONS 2
`define NUM_INPUTS 15

// shared word memory and where each operand lives in it.
`define MEM_DEPTH 64
`define MEM_ADDR_W 6
`define ACT_BASE 0
`define NEURON_BASE 16
`define NEURON_STRIDE 16

// the output keeps bits RESULT_MSB down to FRAC_LSB of the sum.
`define FRAC_LSB 13
`define RESULT_MSB 28

// AXI4-Lite register map, byte addresses.
`define AXI_ADDR_W 12
`define REG_CTRL 'h000
`define REG_STATUS 'h004
`define REG_RESULT_BASE 'h010
`define MEM_WINDOW 'h400

`endif

/* verilog/memArbiter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "layer_cfg.svh"

module memArbiter
	import layerPkg::*;
#(
	parameter int NUM_PORTS = 3
)
(
	input wire clk,
	input wire reset,
	input wire memReq_t portReq [NUM_PORTS],
	output memRsp_t portRsp [NUM_PORTS],
	output memReq_t memReq,
	input wire [31:0] memRdata
);

	localparam int PTR_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

	logic [PTR_W-1:0] ptr;
	logic [PTR_W-1:0] winner;
	logic anyGnt;
	logic rdPending;
	logic [PTR_W-1:0] rdPort;

	// search starts at ptr and wraps, so the first requester found wins.
	always_comb
	begin
		int idx;
		anyGnt = 1'b0;
		winner = '0;
		for (int i = 0; i < NUM_PORTS; i++)
		begin
			idx = int'(ptr) + i;
			if (idx >= NUM_PORTS)
				idx = idx - NUM_PORTS;
			if (!anyGnt && portReq[idx].req)
			begin
				anyGnt = 1'b1;
				winner = PTR_W'(idx);
			end
		end
	end

	always_comb
	begin
		memReq = anyGnt ? portReq[winner] : '0;
		for (int k = 0; k < NUM_PORTS; k++)
		begin
			portRsp[k].gnt = anyGnt && (winner == PTR_W'(k));
			portRsp[k].rdValid = rdPending && (rdPort == PTR_W'(k));
			portRsp[k].rdata = portRsp[k].rdValid ? memRdata : '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ptr <= '0;
			rdPending <= 1'b0;
		end
		else
		begin
			rdPending <= anyGnt && !portReq[winner].write;
			if (anyGnt)
				ptr <= (winner == PTR_W'(NUM_PORTS - 1)) ? '0 : winner + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (anyGnt)
			rdPort <= winner;
	end

endmodule

`default_nettype wire

/* verilog/neuronEngine.sv */
`timescale 1ns/1ns
`default_nettype none

`include "layer_cfg.svh"

module neuronEngine
	import layerPkg::*;
(
	input wire clk,
	input wire reset,
	input wire start,
	input wire [`MEM_ADDR_W-1:0] neuronBase,
	output memReq_t memReq,
	input wire memRsp_t memRsp,
	output logic done,
	output logic [31:0] result
);

	localparam int AW = `MEM_ADDR_W;
	localparam int CNT_W = $clog2(`NUM_INPUTS + 1);

	typedef enum logic [2:0] {
		idle,
		fetchAct,
		waitAct,
		fetchWgt,
		waitWgt,
		fetchBias,
		waitBias
	} state_t;

	state_t state;
	logic [CNT_W-1:0] idx;
	logic [31:0] act;
	logic [31:0] acc;
	logic [31:0] product;
	logic [31:0] biasSum;
	logic lastPair;

	// the low 32 bits of the product are the same for signed and unsigned operands.
	assign product = act * memRsp.rdata;
	assign biasSum = acc + memRsp.rdata;
	assign lastPair = (idx == CNT_W'(`NUM_INPUTS - 1));

	always_comb
	begin
		memReq.req = (state == fetchAct) || (state == fetchWgt) || (state == fetchBias);
		memReq.write = 1'b0;
		memReq.wdata = '0;
		case (state)
			fetchAct:
				memReq.addr = AW'(`ACT_BASE) + AW'(idx);
			fetchWgt:
				memReq.addr = neuronBase + AW'(idx);
			default:
				memReq.addr = neuronBase + AW'(`NUM_INPUTS);
		endcase
	end

	// ****************************************
	// fetch and accumulate FSM
	// ****************************************

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			idx <= '0;
			done <= 1'b0;
			result <= '0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				idle:
				begin
					if (start)
					begin
						idx <= '0;
						state <= fetchAct;
					end
				end
				fetchAct:
				begin
					if (memRsp.gnt)
						state <= waitAct;
				end
				waitAct:
				begin
					if (memRsp.rdValid)
						state <= fetchWgt;
				end
				fetchWgt:
				begin
					if (memRsp.gnt)
						state <= waitWgt;
				end
				waitWgt:
				begin
					if (memRsp.rdValid)
					begin
						if (lastPair)
						begin
							state <= fetchBias;
						end
						else
						begin
							idx <= idx + 1'b1;
							state <= fetchAct;
						end
					end
				end
				fetchBias:
				begin
					if (memRsp.gnt)
						state <= waitBias;
				end
				waitBias:
				begin
					if (memRsp.rdValid)
					begin
						// ReLU on the 13 fraction bit sum, keeping bits 28 down to 13.
						result <= biasSum[31] ? 32'd0 : 32'(biasSum[`RESULT_MSB:`FRAC_LSB]);
						done <= 1'b1;
						state <= idle;
					end
				end
				default:
				begin
					state <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == idle && start)
			acc <= '0;
		if (state == waitAct && memRsp.rdValid)
			act <= memRsp.rdata;
		if (state == waitWgt && memRsp.rdValid)
			acc <= acc + product;
	end

endmodule

`default_nettype wire
